// File: logic/rename_pkg.sv
package rename_pkg;

    // ======================================================================
    // Stage geometry
    // ======================================================================
    localparam int NUM_LANES     = 3;
    localparam int XLEN          = 32;
    localparam int ARCH_ADDR_W   = 5;
    localparam int PHYS_ADDR_W   = 6;
    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    // Free list holds every physical register not in the identity map
    localparam int FREE_DEPTH = 32;
    localparam int FREE_PTR_W = 5;
    localparam int FREE_CNT_W = 6;

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;

    // Operation class handed to dispatch
    typedef enum logic [3:0] {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
        OP_LOAD, OP_STORE, OP_IMM, OP_REG, OP_INVALID
    } op_class_e;

endpackage

// File: logic/lane_decoder.sv
`timescale 1ns/1ps

module lane_decoder
    import rename_pkg::*;
(
    input  logic [XLEN-1:0]        instr_i,
    output op_class_e              op_o,
    output logic [ARCH_ADDR_W-1:0] rs1_o,
    output logic [ARCH_ADDR_W-1:0] rs2_o,
    output logic [ARCH_ADDR_W-1:0] rd_o,
    output logic                   uses_rs1_o,
    output logic                   uses_rs2_o,
    output logic                   writes_rd_o
);

    // Register fields sit at fixed positions in every RV32I format
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    always_comb begin
        case (instr_i[6:0])
            OPC_LUI:    op_o = OP_LUI;
            OPC_AUIPC:  op_o = OP_AUIPC;
            OPC_JAL:    op_o = OP_JAL;
            OPC_JALR:   op_o = OP_JALR;
            OPC_BRANCH: op_o = OP_BRANCH;
            OPC_LOAD:   op_o = OP_LOAD;
            OPC_STORE:  op_o = OP_STORE;
            OPC_IMM:    op_o = OP_IMM;
            OPC_REG:    op_o = OP_REG;
            default:    op_o = OP_INVALID;
        endcase
    end

    // Operand usage per class, invalid opcodes touch no registers
    assign uses_rs1_o = (op_o == OP_JALR) || (op_o == OP_BRANCH) || (op_o == OP_LOAD) ||
                        (op_o == OP_STORE) || (op_o == OP_IMM) || (op_o == OP_REG);
    assign uses_rs2_o = (op_o == OP_BRANCH) || (op_o == OP_STORE) || (op_o == OP_REG);
    assign writes_rd_o = (op_o == OP_LUI) || (op_o == OP_AUIPC) || (op_o == OP_JAL) ||
                         (op_o == OP_JALR) || (op_o == OP_LOAD) || (op_o == OP_IMM) ||
                         (op_o == OP_REG);

endmodule

// File: logic/free_list.sv
`timescale 1ns/1ps

module free_list
    import rename_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush_i,
    input  logic                                  group_accept_i,
    input  logic [NUM_LANES-1:0]                  alloc_req_i,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] alloc_phys_o,
    output logic [FREE_CNT_W-1:0]                 free_count_o,
    input  logic [NUM_LANES-1:0]                  commit_valid_i,
    input  logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] commit_phys_i
);

    logic [PHYS_ADDR_W-1:0] queue_q [FREE_DEPTH];
    logic [FREE_PTR_W-1:0]  head_q;
    logic [FREE_PTR_W-1:0]  tail_q;
    logic [FREE_CNT_W-1:0]  count_q;

    logic [FREE_CNT_W-1:0]                 pop_cnt;
    logic [FREE_CNT_W-1:0]                 push_cnt;
    logic [NUM_LANES-1:0][FREE_PTR_W-1:0]  push_ptr;

    // ======================================================================
    // Head window and per-cycle pop/push counts
    // ======================================================================
    always_comb begin
        pop_cnt  = '0;
        push_cnt = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            alloc_phys_o[l] = queue_q[head_q + FREE_PTR_W'(l)];
            if (group_accept_i && alloc_req_i[l]) begin
                pop_cnt = pop_cnt + FREE_CNT_W'(1);
            end
            // Commits land at the tail in lane order
            push_ptr[l] = tail_q + push_cnt[FREE_PTR_W-1:0];
            if (commit_valid_i[l]) begin
                push_cnt = push_cnt + FREE_CNT_W'(1);
            end
        end
    end

    assign free_count_o = count_q;

    // ======================================================================
    // Queue state
    // ======================================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= FREE_CNT_W'(FREE_DEPTH);
            for (int i = 0; i < FREE_DEPTH; i++) begin
                queue_q[i] <= PHYS_ADDR_W'(NUM_ARCH_REGS + i);
            end
        end else if (flush_i) begin
            // Back to the post-reset picture, pending commits are dropped
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= FREE_CNT_W'(FREE_DEPTH);
            for (int i = 0; i < FREE_DEPTH; i++) begin
                queue_q[i] <= PHYS_ADDR_W'(NUM_ARCH_REGS + i);
            end
        end else begin
            head_q  <= head_q + pop_cnt[FREE_PTR_W-1:0];
            tail_q  <= tail_q + push_cnt[FREE_PTR_W-1:0];
            count_q <= count_q - pop_cnt + push_cnt;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (commit_valid_i[l]) begin
                    queue_q[push_ptr[l]] <= commit_phys_i[l];
                end
            end
        end
    end

endmodule

// File: logic/alias_table.sv
`timescale 1ns/1ps

module alias_table
    import rename_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush_i,
    input  logic                                  group_accept_i,
    input  logic [NUM_LANES-1:0]                  lane_valid_i,
    input  logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] rs1_i,
    input  logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] rs2_i,
    input  logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] rd_i,
    input  logic [NUM_LANES-1:0]                  uses_rs1_i,
    input  logic [NUM_LANES-1:0]                  uses_rs2_i,
    input  logic [NUM_LANES-1:0]                  writes_rd_i,
    input  logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] alloc_phys_i,
    output logic [NUM_LANES-1:0]                  alloc_req_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rs1_phys_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rs2_phys_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rd_phys_o
);

    logic [PHYS_ADDR_W-1:0] map_q [NUM_ARCH_REGS];

    // ======================================================================
    // Group rename, lanes resolved in program order
    // ======================================================================
    always_comb begin
        logic [1:0] slot;
        slot = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            // x0 never allocates, so its entry stays at physical 0
            alloc_req_o[l] = lane_valid_i[l] && writes_rd_i[l] && (rd_i[l] != '0);
            rd_phys_o[l]   = alloc_req_o[l] ? alloc_phys_i[slot] : '0;
            if (alloc_req_o[l]) begin
                slot = slot + 2'd1;
            end

            rs1_phys_o[l] = uses_rs1_i[l] ? map_q[rs1_i[l]] : '0;
            rs2_phys_o[l] = uses_rs2_i[l] ? map_q[rs2_i[l]] : '0;
            // Youngest earlier writer in the group overrides the table
            for (int k = 0; k < NUM_LANES; k++) begin
                if (k < l && alloc_req_o[k]) begin
                    if (uses_rs1_i[l] && rd_i[k] == rs1_i[l]) begin
                        rs1_phys_o[l] = rd_phys_o[k];
                    end
                    if (uses_rs2_i[l] && rd_i[k] == rs2_i[l]) begin
                        rs2_phys_o[l] = rd_phys_o[k];
                    end
                end
            end
        end
    end

    // Identity map after reset and flush
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= PHYS_ADDR_W'(i);
            end
        end else if (flush_i) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= PHYS_ADDR_W'(i);
            end
        end else if (group_accept_i) begin
            // Ascending loop, so the last writer of a register wins
            for (int l = 0; l < NUM_LANES; l++) begin
                if (alloc_req_o[l]) begin
                    map_q[rd_i[l]] <= rd_phys_o[l];
                end
            end
        end
    end

endmodule

// File: logic/issue_register.sv
`timescale 1ns/1ps

module issue_register
    import rename_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush_i,
    input  logic                                  bubble_i,
    input  logic                                  group_accept_i,
    input  logic [NUM_LANES-1:0]                  lane_valid_i,
    input  op_class_e [NUM_LANES-1:0]             op_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]        pc_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]        imm_i,
    input  logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rs1_phys_i,
    input  logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rs2_phys_i,
    input  logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rd_phys_i,
    input  logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] rd_arch_i,
    output logic [NUM_LANES-1:0]                  dispatch_valid_o,
    output op_class_e [NUM_LANES-1:0]             dispatch_op_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]        dispatch_pc_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]        dispatch_imm_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rs1_phys_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rs2_phys_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rd_phys_o,
    output logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] dispatch_rd_arch_o
);

    // Valid bits live only for the cycle after an accept
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dispatch_valid_o <= '0;
        end else if (flush_i || bubble_i) begin
            dispatch_valid_o <= '0;
        end else if (group_accept_i) begin
            dispatch_valid_o <= lane_valid_i;
        end else begin
            dispatch_valid_o <= '0;
        end
    end

    // Payload holds between accepts, empty lanes are zeroed
    always_ff @(posedge clk) begin
        if (group_accept_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                dispatch_op_o[l]       <= lane_valid_i[l] ? op_i[l] : op_class_e'(4'd0);
                dispatch_pc_o[l]       <= lane_valid_i[l] ? pc_i[l] : '0;
                dispatch_imm_o[l]      <= lane_valid_i[l] ? imm_i[l] : '0;
                dispatch_rs1_phys_o[l] <= lane_valid_i[l] ? rs1_phys_i[l] : '0;
                dispatch_rs2_phys_o[l] <= lane_valid_i[l] ? rs2_phys_i[l] : '0;
                dispatch_rd_phys_o[l]  <= lane_valid_i[l] ? rd_phys_i[l] : '0;
                dispatch_rd_arch_o[l]  <= lane_valid_i[l] ? rd_arch_i[l] : '0;
            end
        end
    end

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/1ps

module issue_stage
    import rename_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush_i,
    input  logic                                  bubble_i,
    input  logic [NUM_LANES-1:0]                  decode_valid_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]        instr_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]        pc_i,
    input  logic [NUM_LANES-1:0][XLEN-1:0]        imm_i,
    output logic                                  decode_ready_o,
    input  logic                                  dispatch_ready_i,
    output logic [NUM_LANES-1:0]                  dispatch_valid_o,
    output op_class_e [NUM_LANES-1:0]             dispatch_op_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]        dispatch_pc_o,
    output logic [NUM_LANES-1:0][XLEN-1:0]        dispatch_imm_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rs1_phys_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rs2_phys_o,
    output logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rd_phys_o,
    output logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] dispatch_rd_arch_o,
    input  logic [NUM_LANES-1:0]                  commit_valid_i,
    input  logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] commit_phys_i
);

    op_class_e [NUM_LANES-1:0]             lane_op;
    logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] rs1_arch, rs2_arch, rd_arch, rd_gated;
    logic [NUM_LANES-1:0]                  uses_rs1, uses_rs2, writes_rd;
    logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rs1_phys, rs2_phys, rd_phys, alloc_phys;
    logic [NUM_LANES-1:0]                  alloc_req;
    logic [FREE_CNT_W-1:0]                 free_count;
    logic                                  group_accept;

    // ======================================================================
    // Decode
    // ======================================================================
    lane_decoder u_dec0 (
        .instr_i(instr_i[0]), .op_o(lane_op[0]), .rs1_o(rs1_arch[0]), .rs2_o(rs2_arch[0]),
        .rd_o(rd_arch[0]), .uses_rs1_o(uses_rs1[0]), .uses_rs2_o(uses_rs2[0]),
        .writes_rd_o(writes_rd[0])
    );
    lane_decoder u_dec1 (
        .instr_i(instr_i[1]), .op_o(lane_op[1]), .rs1_o(rs1_arch[1]), .rs2_o(rs2_arch[1]),
        .rd_o(rd_arch[1]), .uses_rs1_o(uses_rs1[1]), .uses_rs2_o(uses_rs2[1]),
        .writes_rd_o(writes_rd[1])
    );
    lane_decoder u_dec2 (
        .instr_i(instr_i[2]), .op_o(lane_op[2]), .rs1_o(rs1_arch[2]), .rs2_o(rs2_arch[2]),
        .rd_o(rd_arch[2]), .uses_rs1_o(uses_rs1[2]), .uses_rs2_o(uses_rs2[2]),
        .writes_rd_o(writes_rd[2])
    );

    // Stores and branches carry no destination downstream
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rd_gated[l] = writes_rd[l] ? rd_arch[l] : '0;
        end
    end

    // Whole group goes in at once, so ready needs room for three writers
    assign decode_ready_o = reset && !flush_i && !bubble_i && dispatch_ready_i &&
                            (free_count >= FREE_CNT_W'(NUM_LANES));
    assign group_accept   = decode_ready_o && (|decode_valid_i);

    // ======================================================================
    // Rename and issue
    // ======================================================================
    alias_table u_rat (
        .clk(clk), .reset(reset), .flush_i(flush_i), .group_accept_i(group_accept),
        .lane_valid_i(decode_valid_i), .rs1_i(rs1_arch), .rs2_i(rs2_arch), .rd_i(rd_gated),
        .uses_rs1_i(uses_rs1), .uses_rs2_i(uses_rs2), .writes_rd_i(writes_rd),
        .alloc_phys_i(alloc_phys), .alloc_req_o(alloc_req),
        .rs1_phys_o(rs1_phys), .rs2_phys_o(rs2_phys), .rd_phys_o(rd_phys)
    );

    free_list u_free (
        .clk(clk), .reset(reset), .flush_i(flush_i), .group_accept_i(group_accept),
        .alloc_req_i(alloc_req), .alloc_phys_o(alloc_phys), .free_count_o(free_count),
        .commit_valid_i(commit_valid_i), .commit_phys_i(commit_phys_i)
    );

    issue_register u_ireg (
        .clk(clk), .reset(reset), .flush_i(flush_i), .bubble_i(bubble_i),
        .group_accept_i(group_accept), .lane_valid_i(decode_valid_i), .op_i(lane_op),
        .pc_i(pc_i), .imm_i(imm_i), .rs1_phys_i(rs1_phys), .rs2_phys_i(rs2_phys),
        .rd_phys_i(rd_phys), .rd_arch_i(rd_gated),
        .dispatch_valid_o(dispatch_valid_o), .dispatch_op_o(dispatch_op_o),
        .dispatch_pc_o(dispatch_pc_o), .dispatch_imm_o(dispatch_imm_o),
        .dispatch_rs1_phys_o(dispatch_rs1_phys_o), .dispatch_rs2_phys_o(dispatch_rs2_phys_o),
        .dispatch_rd_phys_o(dispatch_rd_phys_o), .dispatch_rd_arch_o(dispatch_rd_arch_o)
    );

endmodule

// File: dv/issue_stage_checker.sv
`timescale 1ns/1ps

module issue_stage_checker
    import rename_pkg::*;
(
    input logic                                  clk,
    input logic                                  reset,
    input logic                                  flush_i,
    input logic                                  bubble_i,
    input logic                                  decode_ready_o,
    input logic [NUM_LANES-1:0]                  dispatch_valid_o,
    input logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rd_phys_o
);

    // Two live lanes never share a newly allocated register
    function automatic bit rd_unique(logic [NUM_LANES-1:0] v,
                                     logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] rd);
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int j = i + 1; j < NUM_LANES; j++) begin
                if (v[i] && v[j] && rd[i] != '0 && rd[i] == rd[j]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    assert property (@(posedge clk) disable iff (!reset)
        (flush_i || bubble_i) |-> !decode_ready_o)
        else $error("decode_ready_o high during flush or bubble");

    assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> (dispatch_valid_o == '0))
        else $error("dispatch_valid_o set in the cycle after a flush");

    assert property (@(posedge clk) disable iff (!reset)
        rd_unique(dispatch_valid_o, dispatch_rd_phys_o))
        else $error("two dispatch lanes carry the same rd_phys");

endmodule

bind issue_stage issue_stage_checker u_checker (
    .clk(clk), .reset(reset), .flush_i(flush_i), .bubble_i(bubble_i),
    .decode_ready_o(decode_ready_o), .dispatch_valid_o(dispatch_valid_o),
    .dispatch_rd_phys_o(dispatch_rd_phys_o)
);

// File: dv/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb
    import rename_pkg::*;
;

    logic                                  clk;
    logic                                  reset;
    logic                                  flush_i;
    logic                                  bubble_i;
    logic [NUM_LANES-1:0]                  decode_valid_i;
    logic [NUM_LANES-1:0][XLEN-1:0]        instr_i;
    logic [NUM_LANES-1:0][XLEN-1:0]        pc_i;
    logic [NUM_LANES-1:0][XLEN-1:0]        imm_i;
    logic                                  decode_ready_o;
    logic                                  dispatch_ready_i;
    logic [NUM_LANES-1:0]                  dispatch_valid_o;
    op_class_e [NUM_LANES-1:0]             dispatch_op_o;
    logic [NUM_LANES-1:0][XLEN-1:0]        dispatch_pc_o;
    logic [NUM_LANES-1:0][XLEN-1:0]        dispatch_imm_o;
    logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rs1_phys_o;
    logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rs2_phys_o;
    logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] dispatch_rd_phys_o;
    logic [NUM_LANES-1:0][ARCH_ADDR_W-1:0] dispatch_rd_arch_o;
    logic [NUM_LANES-1:0]                  commit_valid_i;
    logic [NUM_LANES-1:0][PHYS_ADDR_W-1:0] commit_phys_i;

    integer seed = 55;
    int     errors = 0;
    int     checks = 0;

    // Reference model state
    int map_m [NUM_ARCH_REGS];
    int free_q [$];
    int displaced_q [$];
    logic [NUM_LANES-1:0] exp_valid;
    bit seen_accept = 1'b0;
    int exp_op [NUM_LANES];
    int exp_pc [NUM_LANES];
    int exp_imm [NUM_LANES];
    int exp_rs1 [NUM_LANES];
    int exp_rs2 [NUM_LANES];
    int exp_rd [NUM_LANES];
    int exp_rd_arch [NUM_LANES];

    issue_stage u_dut (.*);

    always #20 clk = ~clk;

    function automatic int rnd(int n);
        return ($random(seed) & 32'h7fffffff) % n;
    endfunction

    function automatic op_class_e class_of(logic [6:0] opc);
        case (opc)
            OPC_LUI:    return OP_LUI;
            OPC_AUIPC:  return OP_AUIPC;
            OPC_JAL:    return OP_JAL;
            OPC_JALR:   return OP_JALR;
            OPC_BRANCH: return OP_BRANCH;
            OPC_LOAD:   return OP_LOAD;
            OPC_STORE:  return OP_STORE;
            OPC_IMM:    return OP_IMM;
            OPC_REG:    return OP_REG;
            default:    return OP_INVALID;
        endcase
    endfunction

    task automatic check_val(string name, int exp, int act);
        checks++;
        assert (exp == act) else begin
            $display("[ERROR] %s expected %0d actual %0d at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    task automatic model_reset();
        free_q.delete();
        displaced_q.delete();
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            map_m[i] = i;
        end
        for (int i = 0; i < FREE_DEPTH; i++) begin
            free_q.push_back(NUM_ARCH_REGS + i);
        end
    endtask

    // Compare what dispatch shows against the group accepted one cycle ago
    task automatic check_dispatch();
        for (int l = 0; l < NUM_LANES; l++) begin
            check_val($sformatf("valid[%0d]", l), exp_valid[l], dispatch_valid_o[l]);
            // Payload keeps the last accepted group through idle cycles
            if (seen_accept) begin
                check_val($sformatf("op[%0d]", l), exp_op[l], dispatch_op_o[l]);
                check_val($sformatf("pc[%0d]", l), exp_pc[l], dispatch_pc_o[l]);
                check_val($sformatf("imm[%0d]", l), exp_imm[l], dispatch_imm_o[l]);
                check_val($sformatf("rs1_phys[%0d]", l), exp_rs1[l], dispatch_rs1_phys_o[l]);
                check_val($sformatf("rs2_phys[%0d]", l), exp_rs2[l], dispatch_rs2_phys_o[l]);
                check_val($sformatf("rd_phys[%0d]", l), exp_rd[l], dispatch_rd_phys_o[l]);
                check_val($sformatf("rd_arch[%0d]", l), exp_rd_arch[l], dispatch_rd_arch_o[l]);
            end
        end
    endtask

    // ======================================================================
    // One cycle of random stimulus and model update
    // ======================================================================
    task automatic drive_cycle(int flush_pct, int commit_pct);
        logic [6:0] opc_list [11];
        logic [6:0] opc;
        int         commit_regs [$];
        int         idx;
        bit         exp_ready;
        op_class_e  cls;
        bit         w_rd;
        int         rd;
        opc_list = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                     OPC_STORE, OPC_IMM, OPC_REG, 7'b1111111, 7'b0001011};
        flush_i          = (rnd(100) < flush_pct);
        bubble_i         = (rnd(100) < 5);
        dispatch_ready_i = (rnd(100) >= 8);
        commit_valid_i   = '0;
        commit_phys_i    = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            decode_valid_i[l] = (rnd(100) < 80);
            opc = opc_list[rnd(11)];
            // Small register range so groups often depend on each other
            instr_i[l] = {7'(rnd(128)), 5'(rnd(8)), 5'(rnd(8)), 3'(rnd(8)), 5'(rnd(8)), opc};
            pc_i[l]    = $random(seed);
            imm_i[l]   = $random(seed);
            if (!flush_i && displaced_q.size() > 0 && rnd(100) < commit_pct) begin
                idx = rnd(displaced_q.size());
                commit_valid_i[l] = 1'b1;
                commit_phys_i[l]  = PHYS_ADDR_W'(displaced_q[idx]);
                commit_regs.push_back(displaced_q[idx]);
                displaced_q.delete(idx);
            end
        end
        #1;
        exp_ready = !flush_i && !bubble_i && dispatch_ready_i && (free_q.size() >= NUM_LANES);
        check_val("decode_ready", exp_ready, decode_ready_o);
        exp_valid = '0;
        if (exp_ready && (|decode_valid_i)) begin
            seen_accept = 1'b1;
            for (int l = 0; l < NUM_LANES; l++) begin
                // Lanes not offered are captured as zero
                exp_op[l]      = 0;
                exp_pc[l]      = 0;
                exp_imm[l]     = 0;
                exp_rs1[l]     = 0;
                exp_rs2[l]     = 0;
                exp_rd[l]      = 0;
                exp_rd_arch[l] = 0;
                if (decode_valid_i[l]) begin
                    cls  = class_of(instr_i[l][6:0]);
                    w_rd = cls inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM,
                                       OP_REG};
                    rd   = instr_i[l][11:7];
                    exp_valid[l]   = 1'b1;
                    exp_op[l]      = cls;
                    exp_pc[l]      = pc_i[l];
                    exp_imm[l]     = imm_i[l];
                    exp_rs1[l]     = (cls inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
                                     OP_IMM, OP_REG}) ? map_m[instr_i[l][19:15]] : 0;
                    exp_rs2[l]     = (cls inside {OP_BRANCH, OP_STORE, OP_REG}) ?
                                     map_m[instr_i[l][24:20]] : 0;
                    exp_rd_arch[l] = w_rd ? rd : 0;
                    // Updating the map lane by lane also covers in-group forwarding
                    if (w_rd && rd != 0) begin
                        exp_rd[l] = free_q.pop_front();
                        displaced_q.push_back(map_m[rd]);
                        map_m[rd] = exp_rd[l];
                    end
                end
            end
        end
        foreach (commit_regs[i]) begin
            free_q.push_back(commit_regs[i]);
        end
        if (flush_i) begin
            model_reset();
        end
    endtask

    task automatic wait_ready(int limit);
        int n;
        n = 0;
        while (!decode_ready_o && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!decode_ready_o) begin
            $display("decode_ready_o did not rise within %0d cycles", limit);
            errors++;
        end
    endtask

    initial begin
        clk              = 1'b0;
        reset            = 1'b0;
        flush_i          = 1'b0;
        bubble_i         = 1'b0;
        decode_valid_i   = '0;
        instr_i          = '0;
        pc_i             = '0;
        imm_i            = '0;
        dispatch_ready_i = 1'b1;
        commit_valid_i   = '0;
        commit_phys_i    = '0;
        exp_valid        = '0;
        model_reset();
        repeat (8) @(negedge clk);
        check_val("reset_ready", 0, decode_ready_o);
        check_val("reset_valid", 0, dispatch_valid_o);
        reset = 1'b1;
        #1;
        wait_ready(20);
        // Drain the free list with few commits before the mixed phase
        for (int c = 0; c < 40; c++) begin
            @(negedge clk);
            check_dispatch();
            drive_cycle(0, 10);
        end
        for (int c = 0; c < 2000; c++) begin
            @(negedge clk);
            check_dispatch();
            drive_cycle(3, 35);
        end
        @(negedge clk);
        check_dispatch();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/rename_pkg.sv
logic/lane_decoder.sv
logic/free_list.sv
logic/alias_table.sv
logic/issue_register.sv
logic/issue_stage.sv
dv/issue_stage_checker.sv
dv/issue_stage_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator
set -u

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Mdir obj_dir \
    --top-module issue_stage_tb -f filelist.f -o issue_stage_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issue_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
